// File: coef_rom.sv
// coefficient ROM, phase row by tap column, registered read
`timescale 1ns/10ps

module coef_rom #(
    parameter int NUM_FIR   = 8,
    parameter int HALFDEPTH = 4
) (
    input  logic                          clk,
    input  logic [$clog2(NUM_FIR)-1:0]    row_i,
    input  logic [$clog2(HALFDEPTH)-1:0]  col_i,
    output resampler_pkg::coef_t          data_o
);
    import resampler_pkg::*;

    coef_t rom [NUM_FIR*HALFDEPTH];

    initial begin
        $readmemh("fir_coef.hex", rom);
    end

    // row-major, row*HALFDEPTH+col with power-of-two HALFDEPTH
    always_ff @(posedge clk) begin
        data_o <= rom[{row_i, col_i}];
    end

endmodule

// File: files.f
resampler_pkg.sv
ring_buffer.sv
coef_rom.sv
slice_scheduler.sv
mac_unit.sv
resampler_seq.sv
resampler_top.sv
tb_resampler.sv

// File: fir_coef.hex
// one Q1.23 coefficient per line, row-major, row = phase 0..7, column = tap 0..3
280000
1C0000
0A0000
FC0000
290000
1B8000
0A4000
FC1000
2A0000
1B0000
0A8000
FC2000
2B0000
1A8000
0AC000
FC3000
2C0000
1A0000
0B0000
FC4000
2D0000
198000
0B4000
FC5000
2E0000
190000
0B8000
FC6000
2F0000
188000
0BC000
FC7000

// File: mac_unit.sv
// shared MAC, pipelined signed multiply with saturating accumulate and 24-bit output
`timescale 1ns/10ps

module mac_unit (
    input  logic                       clk,
    input  logic                       rst,
    input  resampler_pkg::mac_ctrl_t   ctrl_i,
    input  resampler_pkg::sample_t     mpcand_i,
    input  resampler_pkg::coef_t       mplier_i,
    output resampler_pkg::sample_t     result_o
);
    import resampler_pkg::*;

    sample_t a_q;
    coef_t b_q;
    logic [MULT_LATENCY-1:0] v_pipe;
    prod_t prod_pipe [1:MULT_LATENCY-1];
    logic signed [47:0] full_prod;
    logic signed [47:0] shifted;
    acc_t acc_q;
    logic done_q;

    assign full_prod = a_q * b_q;
    assign shifted   = full_prod >>> 23;   // back to Q1.23 scale

    // operand stage, then product stages
    always_ff @(posedge clk) begin
        a_q <= mpcand_i;
        b_q <= mplier_i;
        prod_pipe[1] <= shifted[27:0];
        for (int k = 2; k < MULT_LATENCY; k++) begin
            prod_pipe[k] <= prod_pipe[k-1];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            v_pipe <= '0;
            done_q <= 1'b0;
        end else begin
            v_pipe <= {v_pipe[MULT_LATENCY-2:0], ctrl_i.tap_en};
            done_q <= v_pipe[MULT_LATENCY-1];
        end
    end

    always_ff @(posedge clk) begin
        if (ctrl_i.clear) acc_q <= '0;
        else if (v_pipe[MULT_LATENCY-1]) acc_q <= sat_add(acc_q, acc_t'(prod_pipe[MULT_LATENCY-1]));
    end

    // last product just landed, so the sum is final
    always_ff @(posedge clk) begin
        if (done_q && !v_pipe[MULT_LATENCY-1]) result_o <= sat_out(acc_q);
    end

endmodule

// File: resampler_pkg.sv
// resampler shared types, MAC control, sequencer states and saturation helpers
package resampler_pkg;

    typedef logic signed [23:0] sample_t;   // audio sample
    typedef logic signed [23:0] coef_t;     // Q1.23 coefficient
    typedef logic signed [27:0] prod_t;     // product after >>> 23
    typedef logic signed [31:0] acc_t;

    localparam int MULT_LATENCY = 3;

    typedef struct packed {
        logic clear;    // empty the accumulator
        logic tap_en;   // operands this cycle are a real tap
    } mac_ctrl_t;

    typedef enum logic [2:0] {
        ST_READY,
        ST_RWING,
        ST_LWING,
        ST_DRAIN,
        ST_SATURATE,
        ST_END,
        ST_IDLE
    } seq_state_t;

    function automatic acc_t sat_add(acc_t a, acc_t b);
        logic signed [32:0] s;
        s = {a[31], a} + {b[31], b};
        if (s[32] != s[31]) begin
            return s[32] ? 32'sh8000_0000 : 32'sh7fff_ffff;
        end
        return s[31:0];
    endfunction

    // clamp to 24-bit range
    function automatic sample_t sat_out(acc_t a);
        if (a > 32'sd8388607) return 24'sh7f_ffff;
        if (a < -32'sd8388608) return 24'sh80_0000;
        return a[23:0];
    endfunction

endpackage

// File: resampler_seq.sv
// per-slice sequencer, phase memory and tap addressing for the shared MAC
`timescale 1ns/10ps

module resampler_seq #(
    parameter int NUM_CH    = 2,
    parameter int HALFDEPTH = 4,
    parameter int NUM_FIR   = 8,
    parameter int DECIM     = 5
) (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          slice_start_i,
    input  logic [$clog2(NUM_CH)-1:0]     cur_ch_i,
    input  logic                          cur_req_i,
    output logic [NUM_CH-1:0]             served_o,
    output logic [$clog2(NUM_FIR)-1:0]    rom_row_o,
    output logic [$clog2(HALFDEPTH)-1:0]  rom_col_o,
    output logic [$clog2(HALFDEPTH):0]    offset_o,
    output resampler_pkg::mac_ctrl_t      mac_ctrl_o,
    output logic [NUM_CH-1:0]             pop_o,
    output logic [NUM_CH-1:0]             ack_o
);
    import resampler_pkg::*;

    localparam int RW    = $clog2(NUM_FIR);
    localparam int HW    = $clog2(HALFDEPTH);
    localparam int CNT_W = $clog2(HALFDEPTH + MULT_LATENCY + 1);

    seq_state_t state_q;
    logic go_q;                         // request seen at slice start
    logic [CNT_W-1:0] cnt_q;
    logic [RW-1:0] phase_mem [NUM_CH];
    logic [RW-1:0] phase_cur;
    logic [HW-1:0] tap_d;
    logic wrap;
    logic [NUM_CH-1:0] ch_sel;
    mac_ctrl_t ctrl_d;

    assign phase_cur = phase_mem[cur_ch_i];
    assign wrap      = int'(phase_cur) >= NUM_FIR - DECIM;
    assign ch_sel    = NUM_CH'(1) << cur_ch_i;

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= ST_IDLE;
            go_q    <= 1'b0;
            cnt_q   <= '0;
        end else if (slice_start_i) begin
            state_q <= ST_READY;
            go_q    <= cur_req_i;
            cnt_q   <= '0;
        end else begin
            cnt_q <= cnt_q + 1'b1;
            case (state_q)
                ST_READY: begin
                    cnt_q <= '0;
                    if (go_q) state_q <= ST_RWING;
                end
                ST_RWING, ST_LWING: begin
                    if (cnt_q == CNT_W'(HALFDEPTH - 1)) begin
                        state_q <= (state_q == ST_RWING) ? ST_LWING : ST_DRAIN;
                        cnt_q   <= '0;
                    end
                end
                ST_DRAIN: begin
                    if (cnt_q == CNT_W'(MULT_LATENCY)) state_q <= ST_SATURATE;
                end
                ST_SATURATE: state_q <= ST_END;
                ST_END: begin
                    state_q <= ST_IDLE;
                    go_q    <= 1'b0;
                end
                default: state_q <= ST_IDLE;
            endcase
        end
    end

    // advance by DECIM modulo NUM_FIR
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < NUM_CH; i++) begin
                phase_mem[i] <= '0;
            end
        end else if (state_q == ST_END) begin
            if (wrap) phase_mem[cur_ch_i] <= RW'(int'(phase_cur) + DECIM - NUM_FIR);
            else phase_mem[cur_ch_i] <= RW'(int'(phase_cur) + DECIM);
        end
    end

    // right wing counts taps down, left wing up
    assign tap_d = (state_q == ST_RWING) ? HW'(HALFDEPTH - 1) - cnt_q[HW-1:0]
                                         : cnt_q[HW-1:0];

    assign rom_row_o = (state_q == ST_RWING) ? RW'(NUM_FIR - 1 - int'(phase_cur)) : phase_cur;
    assign rom_col_o = tap_d;
    assign offset_o  = (state_q == ST_RWING) ? {1'b1, tap_d} : {1'b0, ~tap_d}; // H+d / H-1-d

    assign ctrl_d.clear  = (state_q == ST_READY);
    assign ctrl_d.tap_en = (state_q == ST_RWING) || (state_q == ST_LWING);

    // one cycle to line up with ROM and buffer reads
    always_ff @(posedge clk) begin
        if (rst) mac_ctrl_o <= '0;
        else mac_ctrl_o <= ctrl_d;
    end

    assign ack_o    = (state_q == ST_END) ? ch_sel : '0;
    assign pop_o    = (state_q == ST_END && wrap) ? ch_sel : '0;
    assign served_o = ack_o;

endmodule

// File: resampler_top.sv
// multichannel polyphase resampler, ring buffers sharing one MAC and ROM by time slice
`timescale 1ns/10ps

module resampler_top #(
    parameter int NUM_CH    = 2,
    parameter int HALFDEPTH = 4,
    parameter int NUM_FIR   = 8,
    parameter int DECIM     = 5,
    parameter int TIMESLICE = 16
) (
    input  logic                                clk,
    input  logic                                rst,
    input  logic [NUM_CH-1:0]                   rst_ch_i,
    input  logic [NUM_CH-1:0]                   wr_i,
    input  resampler_pkg::sample_t [NUM_CH-1:0] wr_data_i,
    input  logic [NUM_CH-1:0]                   req_i,
    output resampler_pkg::sample_t              out_data_o,
    output logic [NUM_CH-1:0]                   ack_o,
    output logic [NUM_CH-1:0]                   pop_o
);
    import resampler_pkg::*;

    localparam int RB_DEPTH = 4 * HALFDEPTH;   // window plus slack for input jitter

    logic slice_start;
    logic [$clog2(NUM_CH)-1:0] cur_ch;
    logic cur_req;
    logic [NUM_CH-1:0] served;
    logic [$clog2(NUM_FIR)-1:0] rom_row;
    logic [$clog2(HALFDEPTH)-1:0] rom_col;
    logic [$clog2(HALFDEPTH):0] offset;
    mac_ctrl_t mac_ctrl;
    coef_t rom_data;
    sample_t rb_data [NUM_CH];

    for (genvar g = 0; g < NUM_CH; g++) begin : g_rb
        ring_buffer #(.DEPTH(RB_DEPTH)) u_rb (
            .clk       (clk),
            .rst       (rst | rst_ch_i[g]),
            .wr_i      (wr_i[g]),
            .wr_data_i (wr_data_i[g]),
            .pop_i     (pop_o[g]),
            .offset_i  ({1'b0, offset}),
            .rd_data_o (rb_data[g])
        );
    end

    slice_scheduler #(.NUM_CH(NUM_CH), .TIMESLICE(TIMESLICE)) u_sched (
        .clk           (clk),
        .rst           (rst),
        .req_i         (req_i),
        .served_i      (served),
        .slice_start_o (slice_start),
        .cur_ch_o      (cur_ch),
        .cur_req_o     (cur_req)
    );

    resampler_seq #(
        .NUM_CH    (NUM_CH),
        .HALFDEPTH (HALFDEPTH),
        .NUM_FIR   (NUM_FIR),
        .DECIM     (DECIM)
    ) u_seq (
        .clk           (clk),
        .rst           (rst),
        .slice_start_i (slice_start),
        .cur_ch_i      (cur_ch),
        .cur_req_i     (cur_req),
        .served_o      (served),
        .rom_row_o     (rom_row),
        .rom_col_o     (rom_col),
        .offset_o      (offset),
        .mac_ctrl_o    (mac_ctrl),
        .pop_o         (pop_o),
        .ack_o         (ack_o)
    );

    coef_rom #(.NUM_FIR(NUM_FIR), .HALFDEPTH(HALFDEPTH)) u_rom (
        .clk    (clk),
        .row_i  (rom_row),
        .col_i  (rom_col),
        .data_o (rom_data)
    );

    mac_unit u_mac (
        .clk      (clk),
        .rst      (rst),
        .ctrl_i   (mac_ctrl),
        .mpcand_i (rb_data[cur_ch]),   // granted channel only
        .mplier_i (rom_data),
        .result_o (out_data_o)
    );

endmodule

// File: ring_buffer.sv
// ring buffer, per-channel circular sample store with offset read from the tail
`timescale 1ns/10ps

module ring_buffer #(
    parameter int DEPTH = 16
) (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      wr_i,
    input  resampler_pkg::sample_t    wr_data_i,
    input  logic                      pop_i,
    input  logic [$clog2(DEPTH)-1:0]  offset_i,
    output resampler_pkg::sample_t    rd_data_o
);
    import resampler_pkg::*;

    localparam int PW = $clog2(DEPTH);

    sample_t mem [DEPTH];
    logic [PW-1:0] head_q;
    logic [PW-1:0] tail_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            head_q <= '0;
            tail_q <= '0;
        end else begin
            if (wr_i) head_q <= head_q + 1'b1;
            if (pop_i) tail_q <= tail_q + 1'b1;   // one sample consumed
        end
    end

    always_ff @(posedge clk) begin
        if (wr_i) mem[head_q] <= wr_data_i;
    end

    // pointer arithmetic wraps, DEPTH is a power of two
    always_ff @(posedge clk) begin
        rd_data_o <= mem[tail_q + offset_i];
    end

endmodule

// File: run.sh
#!/usr/bin/env bash
# build the resampler testbench with Verilator and run it from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/10ps -Wno-fatal \
    --top-module tb_resampler -f files.f
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

./obj_dir/Vtb_resampler
status=$?
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi
exit 0

// File: slice_scheduler.sv
// time-slice arbiter, round-robin grant of the shared MAC and ROM per channel
`timescale 1ns/10ps

module slice_scheduler #(
    parameter int NUM_CH    = 2,
    parameter int TIMESLICE = 16
) (
    input  logic                       clk,
    input  logic                       rst,
    input  logic [NUM_CH-1:0]          req_i,
    input  logic [NUM_CH-1:0]          served_i,
    output logic                       slice_start_o,
    output logic [$clog2(NUM_CH)-1:0]  cur_ch_o,
    output logic                       cur_req_o
);
    localparam int TW  = $clog2(TIMESLICE);
    localparam int CHW = $clog2(NUM_CH);

    logic [TW-1:0] slot_q;
    logic [NUM_CH-1:0] req_q;

    // starts at the last slot so channel 0 opens the first slice
    always_ff @(posedge clk) begin
        if (rst) begin
            slot_q        <= TW'(TIMESLICE - 1);
            cur_ch_o      <= CHW'(NUM_CH - 1);
            slice_start_o <= 1'b0;
        end else if (slot_q == TW'(TIMESLICE - 1)) begin
            slot_q        <= '0;
            slice_start_o <= 1'b1;
            cur_ch_o      <= (cur_ch_o == CHW'(NUM_CH - 1)) ? '0 : cur_ch_o + 1'b1;
        end else begin
            slot_q        <= slot_q + 1'b1;
            slice_start_o <= 1'b0;
        end
    end

    // new request merges with a pending one
    always_ff @(posedge clk) begin
        if (rst) req_q <= '0;
        else req_q <= (req_q & ~served_i) | req_i;
    end

    assign cur_req_o = req_q[cur_ch_o];

endmodule

// File: tb_resampler.sv
// resampler testbench, directed tests against a reference model on the same coefficients
`timescale 1ns/10ps

module tb_resampler;
    import resampler_pkg::*;

    localparam int NUM_CH    = 2;
    localparam int HALFDEPTH = 4;
    localparam int NUM_FIR   = 8;
    localparam int DECIM     = 5;
    localparam int TIMESLICE = 16;
    localparam int TIMEOUT   = 8 * TIMESLICE;
    localparam int FILL      = 4 * HALFDEPTH;   // one full ring buffer
    localparam longint ACC_MAX = 64'sd2147483647;
    localparam longint ACC_MIN = -64'sd2147483648;
    localparam longint OUT_MAX = 64'sd8388607;
    localparam longint OUT_MIN = -64'sd8388608;

    logic clk = 1'b0;
    logic rst;
    logic [NUM_CH-1:0] rst_ch;
    logic [NUM_CH-1:0] wr;
    sample_t [NUM_CH-1:0] wr_data;
    logic [NUM_CH-1:0] req;
    sample_t out_data;
    logic [NUM_CH-1:0] ack;
    logic [NUM_CH-1:0] pop;

    // reference model, absolute sample positions per channel
    coef_t model_coef [NUM_FIR*HALFDEPTH];
    sample_t model_mem [NUM_CH][64];
    int model_wr [NUM_CH];
    int model_tail [NUM_CH];
    int model_phase [NUM_CH];
    integer seed = 32'h5e7c;

    resampler_top #(
        .NUM_CH    (NUM_CH),
        .HALFDEPTH (HALFDEPTH),
        .NUM_FIR   (NUM_FIR),
        .DECIM     (DECIM),
        .TIMESLICE (TIMESLICE)
    ) dut0 (
        .clk        (clk),
        .rst        (rst),
        .rst_ch_i   (rst_ch),
        .wr_i       (wr),
        .wr_data_i  (wr_data),
        .req_i      (req),
        .out_data_o (out_data),
        .ack_o      (ack),
        .pop_o      (pop)
    );

    always #4 clk = ~clk;

    task automatic abort_run();
        $display("Regression failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [23:0] value,
                               input logic [23:0] expected);
        assert (value == expected) else begin
            $display("[FAIL] %0t %s got %h expected %h", $time, name, value, expected);
            abort_run();
        end
    endtask

    function automatic longint clamp(input longint v, input longint lo, input longint hi);
        if (v > hi) return hi;
        if (v < lo) return lo;
        return v;
    endfunction

    function automatic longint tap_product(input sample_t s, input coef_t c);
        return (longint'(s) * longint'(c)) >>> 23;
    endfunction

    // expected output of one slice, then phase and tail advance
    task automatic model_step(input int ch, output sample_t exp_out,
                              output logic [NUM_CH-1:0] exp_pop);
        longint acc;
        int base;
        int ph;
        int d;
        acc = 0;
        base = model_tail[ch] + HALFDEPTH;
        ph = model_phase[ch];
        for (d = HALFDEPTH - 1; d >= 0; d--) begin
            acc = clamp(acc + tap_product(model_mem[ch][base + d],
                        model_coef[(NUM_FIR - 1 - ph) * HALFDEPTH + d]), ACC_MIN, ACC_MAX);
        end
        for (d = 0; d < HALFDEPTH; d++) begin
            acc = clamp(acc + tap_product(model_mem[ch][base - 1 - d],
                        model_coef[ph * HALFDEPTH + d]), ACC_MIN, ACC_MAX);
        end
        exp_out = sample_t'(clamp(acc, OUT_MIN, OUT_MAX));
        exp_pop = '0;
        if (ph >= NUM_FIR - DECIM) begin
            exp_pop[ch] = 1'b1;
            model_phase[ch] = ph + DECIM - NUM_FIR;
            model_tail[ch] = model_tail[ch] + 1;
        end else begin
            model_phase[ch] = ph + DECIM;
        end
    endtask

    task automatic push_sample(input int ch, input sample_t s);
        @(posedge clk);
        #1;
        wr = '0;
        wr[ch] = 1'b1;
        wr_data[ch] = s;
        model_mem[ch][model_wr[ch]] = s;
        model_wr[ch] = model_wr[ch] + 1;
    endtask

    task automatic fill_channel(input int ch, input bit use_level, input sample_t level);
        int r;
        repeat (FILL) begin
            r = $random(seed);
            push_sample(ch, use_level ? level : sample_t'(r >>> 10));  // moderate levels
        end
        @(posedge clk);
        #1;
        wr = '0;
    endtask

    task automatic reset_channel(input int ch);
        @(posedge clk);
        #1;
        rst_ch[ch] = 1'b1;
        @(posedge clk);
        #1;
        rst_ch = '0;
        model_wr[ch] = 0;
        model_tail[ch] = 0;   // phase survives a buffer reset
    endtask

    task automatic pulse_req(input logic [NUM_CH-1:0] mask);
        @(posedge clk);
        #1;
        req = mask;
        @(posedge clk);
        #1;
        req = '0;
    endtask

    // returns at the falling edge inside the END cycle
    task automatic wait_ack(output logic [NUM_CH-1:0] seen);
        int n;
        n = 0;
        seen = '0;
        while (seen == '0 && n < TIMEOUT) begin
            @(negedge clk);
            if (ack != '0) seen = ack;
            else check_value("pop_o", pop, '0);   // pop only with ack
            n++;
        end
        if (seen == '0) begin
            $display("timeout at %0t, no ack_o within %0d cycles", $time, TIMEOUT);
            abort_run();
        end
    endtask

    task automatic expect_output(input int ch, output sample_t value);
        logic [NUM_CH-1:0] seen;
        logic [NUM_CH-1:0] exp_pop;
        logic [NUM_CH-1:0] exp_ack;
        sample_t exp_out;
        model_step(ch, exp_out, exp_pop);
        exp_ack = '0;
        exp_ack[ch] = 1'b1;
        wait_ack(seen);
        check_value("ack_o", seen, exp_ack);
        check_value("out_data_o", out_data, exp_out);
        check_value("pop_o", pop, exp_pop);
        value = out_data;
    endtask

    task automatic expect_quiet(input int cycles);
        repeat (cycles) begin
            @(negedge clk);
            check_value("ack_o", ack, '0);
            check_value("pop_o", pop, '0);
        end
    endtask

    task automatic idle_after_reset();
        expect_quiet(4 * TIMESLICE);
    endtask

    task automatic single_request_ch0();
        sample_t value;
        fill_channel(0, 1'b0, '0);
        pulse_req(2'b01);
        expect_output(0, value);
        expect_quiet(NUM_CH * TIMESLICE);   // no second ack
    endtask

    task automatic phase_run_ch1();
        sample_t value;
        fill_channel(1, 1'b0, '0);
        repeat (10) begin
            pulse_req(2'b10);
            expect_output(1, value);
        end
    endtask

    task automatic both_channels_at_once();
        sample_t value;
        // last ack closed a channel 1 slice, land mid-way into the next one
        repeat (TIMESLICE + TIMESLICE / 2) @(posedge clk);
        pulse_req(2'b11);
        expect_output(0, value);
        expect_output(1, value);
        expect_quiet(NUM_CH * TIMESLICE);
    endtask

    task automatic saturation_clamps();
        sample_t value;
        reset_channel(0);
        fill_channel(0, 1'b1, 24'sh7f_ffff);
        pulse_req(2'b01);
        expect_output(0, value);
        check_value("out_data_o", value, 24'h7f_ffff);
        reset_channel(0);
        fill_channel(0, 1'b1, 24'sh80_0000);   // wing sums are positive
        pulse_req(2'b01);
        expect_output(0, value);
        check_value("out_data_o", value, 24'h80_0000);
    endtask

    task automatic channel_reset_keeps_phase();
        sample_t value;
        reset_channel(1);
        fill_channel(1, 1'b0, '0);
        pulse_req(2'b10);
        expect_output(1, value);
    endtask

    initial begin
        int c;
        rst = 1'b1;
        rst_ch = '0;
        wr = '0;
        wr_data = '0;
        req = '0;
        for (c = 0; c < NUM_CH; c++) begin
            model_wr[c] = 0;
            model_tail[c] = 0;
            model_phase[c] = 0;
        end
        $readmemh("fir_coef.hex", model_coef);
        repeat (8) @(posedge clk);
        #1;
        rst = 1'b0;
        $display("idle after reset");
        idle_after_reset();
        $display("single request on channel 0");
        single_request_ch0();
        $display("phase sequence on channel 1");
        phase_run_ch1();
        $display("both channels at once");
        both_channels_at_once();
        $display("saturation");
        saturation_clamps();
        $display("channel 1 buffer reset");
        channel_reset_keeps_phase();
        $display("Regression passed");
        $finish;
    end

endmodule
